// File: hw/exu_cfg_pkg.sv
package exu_cfg_pkg;

   localparam int xlen        = 32;
   localparam int reg_addr_w  = 5;
   localparam int num_regs    = 32;
   localparam int link_offset = 4;  // bl / jirl return address step

   typedef logic [xlen-1:0]       word_t;
   typedef logic [reg_addr_w-1:0] reg_addr_t;

endpackage

// File: hw/exu_op_pkg.sv
package exu_op_pkg;

   // opcode as presented by the decoder at D
   typedef enum logic [4:0] {
      op_add,
      op_sub,
      op_slt,
      op_sltu,
      op_and,
      op_or,
      op_xor,
      op_nor,
      op_sll,
      op_srl,
      op_sra,
      op_lu12i,
      op_beq,
      op_bne,
      op_blt,
      op_bge,
      op_bltu,
      op_bgeu,
      op_b,
      op_bl,
      op_jirl
   } exu_op_e;

   typedef enum logic [3:0] {
      alu_add, alu_sub, alu_slt, alu_sltu,
      alu_and, alu_or, alu_xor, alu_nor,
      alu_sll, alu_srl, alu_sra, alu_lu12i
   } alu_op_e;

   typedef enum logic [3:0] {
      bru_none,
      bru_beq, bru_bne, bru_blt, bru_bge, bru_bltu, bru_bgeu,
      bru_b, bru_bl, bru_jirl
   } bru_op_e;

endpackage

// File: hw/exu_issue_if.sv
`timescale 1ns/1ps

// E-stage instruction state, one per cycle
interface exu_issue_if;

   logic                   valid;
   exu_op_pkg::alu_op_e    alu_op;
   exu_op_pkg::bru_op_e    bru_op;
   exu_cfg_pkg::word_t     a;
   exu_cfg_pkg::word_t     b;
   exu_cfg_pkg::word_t     pc;
   exu_cfg_pkg::word_t     offset;  // branch offset
   exu_cfg_pkg::reg_addr_t rd;
   logic                   wen;

   modport issue (output valid, alu_op, bru_op, a, b, pc, offset, rd, wen);

   modport alu (input a, b, alu_op);

   modport bru (input valid, bru_op, a, b, pc, offset);

   modport wb (input valid, bru_op, rd, wen);

endinterface

// File: hw/exu_reg_file.sv
`timescale 1ns/1ps

module exu_reg_file (
   input  logic                   clk,
   input  logic                   reset,
   input  exu_cfg_pkg::reg_addr_t raddr1,
   input  exu_cfg_pkg::reg_addr_t raddr2,
   input  exu_cfg_pkg::reg_addr_t waddr,
   input  logic                   wen,
   input  exu_cfg_pkg::word_t     wdata,
   output exu_cfg_pkg::word_t     rdata1,
   output exu_cfg_pkg::word_t     rdata2
);

   exu_cfg_pkg::word_t regs [exu_cfg_pkg::num_regs];

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < exu_cfg_pkg::num_regs; i++) begin
            regs[i] <= '0;
         end
      end else if (wen && waddr != '0) begin
         regs[waddr] <= wdata;   // r0 never written
      end
   end

   // write-first, so W results are visible at D
   assign rdata1 = (raddr1 == '0)                 ? '0    :
                   (wen && waddr == raddr1)       ? wdata : regs[raddr1];
   assign rdata2 = (raddr2 == '0)                 ? '0    :
                   (wen && waddr == raddr2)       ? wdata : regs[raddr2];

endmodule

// File: hw/exu_issue.sv
`timescale 1ns/1ps

module exu_issue (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   valid_d,
   input  exu_op_pkg::exu_op_e    op_d,
   input  exu_cfg_pkg::reg_addr_t rs1_d,
   input  exu_cfg_pkg::reg_addr_t rs2_d,
   input  exu_cfg_pkg::reg_addr_t rd_d,
   input  logic                   rf_wen_d,
   input  logic                   use_imm_d,
   input  exu_cfg_pkg::word_t     imm_d,
   input  exu_cfg_pkg::word_t     pc_d,
   input  exu_cfg_pkg::word_t     br_offs_d,
   input  exu_cfg_pkg::word_t     rdata1,
   input  exu_cfg_pkg::word_t     rdata2,
   input  logic                   e_fwd_wen,
   input  exu_cfg_pkg::reg_addr_t e_fwd_rd,
   input  exu_cfg_pkg::word_t     e_fwd_data,
   input  logic                   br_taken_e,
   output exu_cfg_pkg::reg_addr_t raddr1,
   output exu_cfg_pkg::reg_addr_t raddr2,
   exu_issue_if.issue             e_if
);

   exu_op_pkg::alu_op_e    alu_op_d;
   exu_op_pkg::bru_op_e    bru_op_d;
   logic                   wen_d;
   exu_cfg_pkg::reg_addr_t rd_sel_d;
   exu_cfg_pkg::word_t     src1_d;
   exu_cfg_pkg::word_t     src2_d;
   logic                   hit1;
   logic                   hit2;

   assign raddr1 = rs1_d;
   assign raddr2 = rs2_d;

   always_comb begin
      alu_op_d = exu_op_pkg::alu_add;
      bru_op_d = exu_op_pkg::bru_none;
      wen_d    = rf_wen_d;
      rd_sel_d = rd_d;
      case (op_d)
         exu_op_pkg::op_sub:   alu_op_d = exu_op_pkg::alu_sub;
         exu_op_pkg::op_slt:   alu_op_d = exu_op_pkg::alu_slt;
         exu_op_pkg::op_sltu:  alu_op_d = exu_op_pkg::alu_sltu;
         exu_op_pkg::op_and:   alu_op_d = exu_op_pkg::alu_and;
         exu_op_pkg::op_or:    alu_op_d = exu_op_pkg::alu_or;
         exu_op_pkg::op_xor:   alu_op_d = exu_op_pkg::alu_xor;
         exu_op_pkg::op_nor:   alu_op_d = exu_op_pkg::alu_nor;
         exu_op_pkg::op_sll:   alu_op_d = exu_op_pkg::alu_sll;
         exu_op_pkg::op_srl:   alu_op_d = exu_op_pkg::alu_srl;
         exu_op_pkg::op_sra:   alu_op_d = exu_op_pkg::alu_sra;
         exu_op_pkg::op_lu12i: alu_op_d = exu_op_pkg::alu_lu12i;
         exu_op_pkg::op_beq:   bru_op_d = exu_op_pkg::bru_beq;
         exu_op_pkg::op_bne:   bru_op_d = exu_op_pkg::bru_bne;
         exu_op_pkg::op_blt:   bru_op_d = exu_op_pkg::bru_blt;
         exu_op_pkg::op_bge:   bru_op_d = exu_op_pkg::bru_bge;
         exu_op_pkg::op_bltu:  bru_op_d = exu_op_pkg::bru_bltu;
         exu_op_pkg::op_bgeu:  bru_op_d = exu_op_pkg::bru_bgeu;
         exu_op_pkg::op_b:     bru_op_d = exu_op_pkg::bru_b;
         exu_op_pkg::op_bl: begin
            bru_op_d = exu_op_pkg::bru_bl;
            wen_d    = 1'b1;
            rd_sel_d = exu_cfg_pkg::reg_addr_t'(1);  // link goes to r1
         end
         exu_op_pkg::op_jirl:  bru_op_d = exu_op_pkg::bru_jirl;
         default:              alu_op_d = exu_op_pkg::alu_add;
      endcase
      // compares and plain b write nothing
      if (op_d inside {[exu_op_pkg::op_beq : exu_op_pkg::op_b]}) begin
         wen_d = 1'b0;
      end
   end

   // bypass from the instruction in E
   assign hit1   = e_fwd_wen && rs1_d != '0 && e_fwd_rd == rs1_d;
   assign hit2   = e_fwd_wen && rs2_d != '0 && e_fwd_rd == rs2_d;
   assign src1_d = hit1 ? e_fwd_data : rdata1;
   assign src2_d = use_imm_d ? imm_d : (hit2 ? e_fwd_data : rdata2);

   always_ff @(posedge clk) begin
      if (reset) begin
         e_if.valid <= 1'b0;
         e_if.wen   <= 1'b0;
      end else begin
         e_if.valid <= valid_d && !br_taken_e;  // kill shadow of taken branch
         e_if.wen   <= wen_d;
      end
   end

   always_ff @(posedge clk) begin
      e_if.alu_op <= alu_op_d;
      e_if.bru_op <= bru_op_d;
      e_if.a      <= src1_d;
      e_if.b      <= src2_d;
      e_if.pc     <= pc_d;
      e_if.offset <= br_offs_d;
      e_if.rd     <= rd_sel_d;
   end

endmodule

// File: hw/exu_alu.sv
`timescale 1ns/1ps

module exu_alu (
   exu_issue_if.alu           e_if,
   output exu_cfg_pkg::word_t result
);

   logic [4:0] shamt;

   assign shamt = e_if.b[4:0];

   always_comb begin
      case (e_if.alu_op)
         exu_op_pkg::alu_add:
            result = e_if.a + e_if.b;
         exu_op_pkg::alu_sub:
            result = e_if.a - e_if.b;
         exu_op_pkg::alu_slt:
            result = exu_cfg_pkg::word_t'($signed(e_if.a) < $signed(e_if.b));
         exu_op_pkg::alu_sltu:
            result = exu_cfg_pkg::word_t'(e_if.a < e_if.b);
         exu_op_pkg::alu_and:
            result = e_if.a & e_if.b;
         exu_op_pkg::alu_or:
            result = e_if.a | e_if.b;
         exu_op_pkg::alu_xor:
            result = e_if.a ^ e_if.b;
         exu_op_pkg::alu_nor:
            result = ~(e_if.a | e_if.b);
         exu_op_pkg::alu_sll:
            result = e_if.a << shamt;
         exu_op_pkg::alu_srl:
            result = e_if.a >> shamt;
         exu_op_pkg::alu_sra:
            result = exu_cfg_pkg::word_t'($signed(e_if.a) >>> shamt);
         exu_op_pkg::alu_lu12i:
            result = e_if.b << 12;   // upper immediate
         default:
            result = '0;
      endcase
   end

endmodule

// File: hw/exu_bru.sv
`timescale 1ns/1ps

module exu_bru (
   exu_issue_if.bru           e_if,
   output logic               taken,
   output exu_cfg_pkg::word_t target,
   output exu_cfg_pkg::word_t link
);

   logic eq;
   logic lt;
   logic ltu;
   logic cond;
   exu_cfg_pkg::word_t base;

   assign eq  = (e_if.a == e_if.b);
   assign lt  = ($signed(e_if.a) < $signed(e_if.b));
   assign ltu = (e_if.a < e_if.b);

   always_comb begin
      case (e_if.bru_op)
         exu_op_pkg::bru_beq:  cond = eq;
         exu_op_pkg::bru_bne:  cond = !eq;
         exu_op_pkg::bru_blt:  cond = lt;
         exu_op_pkg::bru_bge:  cond = !lt;
         exu_op_pkg::bru_bltu: cond = ltu;
         exu_op_pkg::bru_bgeu: cond = !ltu;
         exu_op_pkg::bru_b,
         exu_op_pkg::bru_bl,
         exu_op_pkg::bru_jirl: cond = 1'b1;  // unconditional
         default:              cond = 1'b0;
      endcase
   end

   assign taken = e_if.valid && cond;

   // jirl is register relative, the rest pc relative
   assign base   = (e_if.bru_op == exu_op_pkg::bru_jirl) ? e_if.a : e_if.pc;
   assign target = base + e_if.offset;

   assign link = e_if.pc + exu_cfg_pkg::word_t'(exu_cfg_pkg::link_offset);

endmodule

// File: hw/exu_wb.sv
`timescale 1ns/1ps

module exu_wb (
   input  logic                   clk,
   input  logic                   reset,
   input  exu_cfg_pkg::word_t     alu_result,
   input  exu_cfg_pkg::word_t     bru_link,
   exu_issue_if.wb                e_if,
   output logic                   e_fwd_wen,
   output exu_cfg_pkg::reg_addr_t e_fwd_rd,
   output exu_cfg_pkg::word_t     e_fwd_data,
   output logic                   rf_wen,
   output exu_cfg_pkg::reg_addr_t rf_waddr,
   output exu_cfg_pkg::word_t     rf_wdata,
   output logic                   wb_valid,
   output exu_cfg_pkg::reg_addr_t wb_rd,
   output exu_cfg_pkg::word_t     wb_data
);

   logic                   is_link;
   logic                   w_valid;
   logic                   w_wen;
   exu_cfg_pkg::reg_addr_t w_rd;
   exu_cfg_pkg::word_t     w_data;

   assign is_link = (e_if.bru_op == exu_op_pkg::bru_bl) ||
                    (e_if.bru_op == exu_op_pkg::bru_jirl);

   // E-stage result, also the bypass value
   assign e_fwd_wen  = e_if.valid && e_if.wen;
   assign e_fwd_rd   = e_if.rd;
   assign e_fwd_data = is_link ? bru_link : alu_result;

   always_ff @(posedge clk) begin
      if (reset) begin
         w_valid <= 1'b0;
         w_wen   <= 1'b0;
      end else begin
         w_valid <= e_if.valid;
         w_wen   <= e_fwd_wen;
      end
   end

   always_ff @(posedge clk) begin
      w_rd   <= e_if.wen ? e_if.rd : '0;  // zero when nothing is written
      w_data <= e_fwd_data;
   end

   assign rf_wen   = w_wen;
   assign rf_waddr = w_rd;
   assign rf_wdata = w_data;

   assign wb_valid = w_valid;
   assign wb_rd    = w_rd;
   assign wb_data  = w_data;

endmodule

// File: hw/exu.sv
`timescale 1ns/1ps

module exu (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   valid_d,
   input  exu_op_pkg::exu_op_e    op_d,
   input  exu_cfg_pkg::reg_addr_t rs1_d,
   input  exu_cfg_pkg::reg_addr_t rs2_d,
   input  exu_cfg_pkg::reg_addr_t rd_d,
   input  logic                   rf_wen_d,
   input  logic                   use_imm_d,
   input  exu_cfg_pkg::word_t     imm_d,
   input  exu_cfg_pkg::word_t     pc_d,
   input  exu_cfg_pkg::word_t     br_offs_d,
   output logic                   br_taken_e,
   output exu_cfg_pkg::word_t     brpc_e,
   output logic                   wb_valid,
   output exu_cfg_pkg::reg_addr_t wb_rd,
   output exu_cfg_pkg::word_t     wb_data
);

   exu_cfg_pkg::reg_addr_t raddr1;
   exu_cfg_pkg::reg_addr_t raddr2;
   exu_cfg_pkg::word_t     rdata1;
   exu_cfg_pkg::word_t     rdata2;
   exu_cfg_pkg::word_t     alu_result;
   exu_cfg_pkg::word_t     bru_link;
   logic                   e_fwd_wen;
   exu_cfg_pkg::reg_addr_t e_fwd_rd;
   exu_cfg_pkg::word_t     e_fwd_data;
   logic                   rf_wen;
   exu_cfg_pkg::reg_addr_t rf_waddr;
   exu_cfg_pkg::word_t     rf_wdata;

   exu_issue_if e_if ();

   exu_reg_file u_reg_file (
      .clk    (clk),
      .reset  (reset),
      .raddr1 (raddr1),
      .raddr2 (raddr2),
      .waddr  (rf_waddr),
      .wen    (rf_wen),
      .wdata  (rf_wdata),
      .rdata1 (rdata1),
      .rdata2 (rdata2)
   );

   exu_issue u_issue (
      .clk        (clk),
      .reset      (reset),
      .valid_d    (valid_d),
      .op_d       (op_d),
      .rs1_d      (rs1_d),
      .rs2_d      (rs2_d),
      .rd_d       (rd_d),
      .rf_wen_d   (rf_wen_d),
      .use_imm_d  (use_imm_d),
      .imm_d      (imm_d),
      .pc_d       (pc_d),
      .br_offs_d  (br_offs_d),
      .rdata1     (rdata1),
      .rdata2     (rdata2),
      .e_fwd_wen  (e_fwd_wen),
      .e_fwd_rd   (e_fwd_rd),
      .e_fwd_data (e_fwd_data),
      .br_taken_e (br_taken_e),
      .raddr1     (raddr1),
      .raddr2     (raddr2),
      .e_if       (e_if.issue)
   );

   exu_alu u_alu (
      .e_if   (e_if.alu),
      .result (alu_result)
   );

   // taken and target leave the unit as the fetch redirect
   exu_bru u_bru (
      .e_if   (e_if.bru),
      .taken  (br_taken_e),
      .target (brpc_e),
      .link   (bru_link)
   );

   exu_wb u_wb (
      .clk        (clk),
      .reset      (reset),
      .alu_result (alu_result),
      .bru_link   (bru_link),
      .e_if       (e_if.wb),
      .e_fwd_wen  (e_fwd_wen),
      .e_fwd_rd   (e_fwd_rd),
      .e_fwd_data (e_fwd_data),
      .rf_wen     (rf_wen),
      .rf_waddr   (rf_waddr),
      .rf_wdata   (rf_wdata),
      .wb_valid   (wb_valid),
      .wb_rd      (wb_rd),
      .wb_data    (wb_data)
   );

endmodule

// File: include/exu_tb_vectors.svh
`ifndef EXU_TB_VECTORS_SVH
`define EXU_TB_VECTORS_SVH

// columns: op, rs1, rs2, rd, rf_wen, use_imm, imm, branch offset, commit data, taken
// pc of row i is 0x1000 + 4*i; data of rows that write nothing is not compared
typedef struct packed {
   exu_op_pkg::exu_op_e    op;
   exu_cfg_pkg::reg_addr_t rs1;
   exu_cfg_pkg::reg_addr_t rs2;
   exu_cfg_pkg::reg_addr_t rd;
   logic                   wen;
   logic                   use_imm;
   exu_cfg_pkg::word_t     imm;
   exu_cfg_pkg::word_t     offs;
   exu_cfg_pkg::word_t     exp_data;
   logic                   exp_taken;
} vec_t;

localparam int num_vectors = 42;

localparam vec_t vectors [num_vectors] = '{
   '{exu_op_pkg::op_add,   5'd7, 5'd0, 5'd5,  1'b1, 1'b0, 32'h0, 32'h0, 32'h0, 1'b0},
   '{exu_op_pkg::op_add,   5'd0, 5'd0, 5'd1,  1'b1, 1'b1, 32'h1234_5678, 32'h0, 32'h1234_5678, 1'b0},
   '{exu_op_pkg::op_add,   5'd0, 5'd0, 5'd2,  1'b1, 1'b1, 32'hffff_fff0, 32'h0, 32'hffff_fff0, 1'b0},
   '{exu_op_pkg::op_sub,   5'd1, 5'd2, 5'd3,  1'b1, 1'b0, 32'h0, 32'h0, 32'h1234_5688, 1'b0},
   '{exu_op_pkg::op_slt,   5'd2, 5'd1, 5'd4,  1'b1, 1'b0, 32'h0, 32'h0, 32'h1, 1'b0},
   '{exu_op_pkg::op_sltu,  5'd2, 5'd1, 5'd4,  1'b1, 1'b0, 32'h0, 32'h0, 32'h0, 1'b0},
   '{exu_op_pkg::op_and,   5'd1, 5'd0, 5'd6,  1'b1, 1'b1, 32'h0000_ffff, 32'h0, 32'h5678, 1'b0},
   '{exu_op_pkg::op_or,    5'd1, 5'd2, 5'd7,  1'b1, 1'b0, 32'h0, 32'h0, 32'hffff_fff8, 1'b0},
   '{exu_op_pkg::op_xor,   5'd1, 5'd3, 5'd8,  1'b1, 1'b0, 32'h0, 32'h0, 32'h0000_00f0, 1'b0},
   '{exu_op_pkg::op_nor,   5'd0, 5'd8, 5'd9,  1'b1, 1'b0, 32'h0, 32'h0, 32'hffff_ff0f, 1'b0},
   '{exu_op_pkg::op_sll,   5'd1, 5'd0, 5'd10, 1'b1, 1'b1, 32'd4, 32'h0, 32'h2345_6780, 1'b0},
   '{exu_op_pkg::op_srl,   5'd2, 5'd0, 5'd11, 1'b1, 1'b1, 32'd4, 32'h0, 32'h0fff_ffff, 1'b0},
   '{exu_op_pkg::op_sra,   5'd2, 5'd0, 5'd12, 1'b1, 1'b1, 32'd36, 32'h0, 32'hffff_ffff, 1'b0},
   '{exu_op_pkg::op_lu12i, 5'd0, 5'd0, 5'd13, 1'b1, 1'b1, 32'h000a_bcde, 32'h0, 32'habcd_e000, 1'b0},
   '{exu_op_pkg::op_add,   5'd1, 5'd0, 5'd0,  1'b1, 1'b1, 32'h1, 32'h0, 32'h1234_5679, 1'b0},
   '{exu_op_pkg::op_add,   5'd0, 5'd0, 5'd14, 1'b1, 1'b0, 32'h0, 32'h0, 32'h0, 1'b0},
   '{exu_op_pkg::op_beq,   5'd1, 5'd1, 5'd0,  1'b0, 1'b0, 32'h0, 32'h100, 32'h0, 1'b1},
   '{exu_op_pkg::op_add,   5'd0, 5'd0, 5'd15, 1'b1, 1'b1, 32'h55, 32'h0, 32'h55, 1'b0},
   '{exu_op_pkg::op_beq,   5'd1, 5'd2, 5'd0,  1'b0, 1'b0, 32'h0, 32'h100, 32'h0, 1'b0},
   '{exu_op_pkg::op_bne,   5'd1, 5'd2, 5'd0,  1'b0, 1'b0, 32'h0, 32'hffff_fff0, 32'h0, 1'b1},
   '{exu_op_pkg::op_add,   5'd0, 5'd0, 5'd15, 1'b1, 1'b1, 32'h55, 32'h0, 32'h55, 1'b0},
   '{exu_op_pkg::op_bne,   5'd1, 5'd1, 5'd0,  1'b0, 1'b0, 32'h0, 32'h8, 32'h0, 1'b0},
   '{exu_op_pkg::op_blt,   5'd2, 5'd1, 5'd0,  1'b0, 1'b0, 32'h0, 32'h8, 32'h0, 1'b1},
   '{exu_op_pkg::op_add,   5'd0, 5'd0, 5'd15, 1'b1, 1'b1, 32'h55, 32'h0, 32'h55, 1'b0},
   '{exu_op_pkg::op_blt,   5'd1, 5'd2, 5'd0,  1'b0, 1'b0, 32'h0, 32'h8, 32'h0, 1'b0},
   '{exu_op_pkg::op_bge,   5'd1, 5'd2, 5'd0,  1'b0, 1'b0, 32'h0, 32'h20, 32'h0, 1'b1},
   '{exu_op_pkg::op_add,   5'd0, 5'd0, 5'd15, 1'b1, 1'b1, 32'h55, 32'h0, 32'h55, 1'b0},
   '{exu_op_pkg::op_bge,   5'd2, 5'd1, 5'd0,  1'b0, 1'b0, 32'h0, 32'h20, 32'h0, 1'b0},
   '{exu_op_pkg::op_bltu,  5'd1, 5'd2, 5'd0,  1'b0, 1'b0, 32'h0, 32'h4, 32'h0, 1'b1},
   '{exu_op_pkg::op_add,   5'd0, 5'd0, 5'd15, 1'b1, 1'b1, 32'h55, 32'h0, 32'h55, 1'b0},
   '{exu_op_pkg::op_bltu,  5'd2, 5'd1, 5'd0,  1'b0, 1'b0, 32'h0, 32'h4, 32'h0, 1'b0},
   '{exu_op_pkg::op_bgeu,  5'd2, 5'd1, 5'd0,  1'b0, 1'b0, 32'h0, 32'h40, 32'h0, 1'b1},
   '{exu_op_pkg::op_add,   5'd0, 5'd0, 5'd15, 1'b1, 1'b1, 32'h55, 32'h0, 32'h55, 1'b0},
   '{exu_op_pkg::op_bgeu,  5'd1, 5'd2, 5'd0,  1'b0, 1'b0, 32'h0, 32'h40, 32'h0, 1'b0},
   '{exu_op_pkg::op_b,     5'd0, 5'd0, 5'd0,  1'b0, 1'b0, 32'h0, 32'h1000, 32'h0, 1'b1},
   '{exu_op_pkg::op_add,   5'd0, 5'd0, 5'd15, 1'b1, 1'b1, 32'h55, 32'h0, 32'h55, 1'b0},
   '{exu_op_pkg::op_bl,    5'd0, 5'd0, 5'd0,  1'b0, 1'b0, 32'h0, 32'h200, 32'h1094, 1'b1},
   '{exu_op_pkg::op_add,   5'd0, 5'd0, 5'd15, 1'b1, 1'b1, 32'h55, 32'h0, 32'h55, 1'b0},
   '{exu_op_pkg::op_jirl,  5'd1, 5'd0, 5'd20, 1'b1, 1'b0, 32'h0, 32'h10, 32'h109c, 1'b1},
   '{exu_op_pkg::op_add,   5'd0, 5'd0, 5'd15, 1'b1, 1'b1, 32'h55, 32'h0, 32'h55, 1'b0},
   '{exu_op_pkg::op_add,   5'd20, 5'd0, 5'd21, 1'b1, 1'b1, 32'h0, 32'h0, 32'h109c, 1'b0},
   '{exu_op_pkg::op_add,   5'd21, 5'd1, 5'd22, 1'b1, 1'b0, 32'h0, 32'h0, 32'h2130, 1'b0}
};

`endif

// File: verification/exu_tb.sv
`timescale 1ns/1ps

module exu_tb;

   `include "exu_tb_vectors.svh"

   localparam int reset_cycles  = 8;
   localparam int drain_timeout = 20;
   localparam int num_random    = 200;

   typedef struct packed {
      logic                   valid;
      logic                   taken;
      exu_cfg_pkg::word_t     target;
      logic                   wen;
      exu_cfg_pkg::reg_addr_t rd;
      exu_cfg_pkg::word_t     data;
   } stage_t;

   logic                   clk;
   logic                   reset;
   logic                   valid_d;
   exu_op_pkg::exu_op_e    op_d;
   exu_cfg_pkg::reg_addr_t rs1_d;
   exu_cfg_pkg::reg_addr_t rs2_d;
   exu_cfg_pkg::reg_addr_t rd_d;
   logic                   rf_wen_d;
   logic                   use_imm_d;
   exu_cfg_pkg::word_t     imm_d;
   exu_cfg_pkg::word_t     pc_d;
   exu_cfg_pkg::word_t     br_offs_d;
   logic                   br_taken_e;
   exu_cfg_pkg::word_t     brpc_e;
   logic                   wb_valid;
   exu_cfg_pkg::reg_addr_t wb_rd;
   exu_cfg_pkg::word_t     wb_data;

   exu_cfg_pkg::word_t model_regs [exu_cfg_pkg::num_regs];
   stage_t             d_st;
   stage_t             e_st;
   stage_t             w_st;
   string              d_name;
   string              e_name;
   string              w_name;
   logic [31:0]        lfsr;
   int                 errors;
   int                 checks;

   exu dut_i (.*);

   always #4 clk = ~clk;

   // Galois LFSR stepped once per bit taken
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] v;
      logic        b;
      v = '0;
      for (int i = 0; i < n; i++) begin
         b    = lfsr[0];
         lfsr = lfsr >> 1;
         if (b) lfsr = lfsr ^ 32'h8020_0003;
         v = (v << 1) | 32'(b);
      end
      return v;
   endfunction

   function automatic exu_cfg_pkg::word_t alu_ref(input exu_op_pkg::exu_op_e op,
                                                  input exu_cfg_pkg::word_t a,
                                                  input exu_cfg_pkg::word_t b);
      case (op)
         exu_op_pkg::op_sub:   return a - b;
         exu_op_pkg::op_slt:   return {31'b0, $signed(a) < $signed(b)};
         exu_op_pkg::op_sltu:  return {31'b0, a < b};
         exu_op_pkg::op_and:   return a & b;
         exu_op_pkg::op_or:    return a | b;
         exu_op_pkg::op_xor:   return a ^ b;
         exu_op_pkg::op_nor:   return ~(a | b);
         exu_op_pkg::op_sll:   return a << b[4:0];
         exu_op_pkg::op_srl:   return a >> b[4:0];
         exu_op_pkg::op_sra:   return exu_cfg_pkg::word_t'($signed(a) >>> b[4:0]);
         exu_op_pkg::op_lu12i: return b << 12;
         default:              return a + b;
      endcase
   endfunction

   task automatic check_value(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
      checks++;
      if (exp !== act) begin
         errors++;
         $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   // E outputs show the previous row and the commit port the row before it
   task automatic compare_outputs();
      if (e_st.valid) begin
         check_value({e_name, " taken"}, 32'(e_st.taken), 32'(br_taken_e));
         if (e_st.taken) check_value({e_name, " target"}, e_st.target, brpc_e);
      end else if (br_taken_e !== 1'b0) begin
         errors++;
         $display("br_taken_e high with no valid instruction in E");
      end
      check_value({w_name, " commit valid"}, 32'(w_st.valid), 32'(wb_valid));
      if (w_st.valid) begin
         check_value({w_name, " commit rd"}, 32'(w_st.rd), 32'(wb_rd));
         if (w_st.wen) check_value({w_name, " commit data"}, w_st.data, wb_data);
      end
   endtask

   task automatic issue(input logic vld, input vec_t v, input exu_cfg_pkg::word_t pc,
                        input logic directed, input string name);
      stage_t             s;
      exu_cfg_pkg::word_t a;
      exu_cfg_pkg::word_t b;
      logic               is_link;
      @(posedge clk);
      #1;
      valid_d   = vld;
      op_d      = v.op;
      rs1_d     = v.rs1;
      rs2_d     = v.rs2;
      rd_d      = v.rd;
      rf_wen_d  = v.wen;
      use_imm_d = v.use_imm;
      imm_d     = v.imm;
      pc_d      = pc;
      br_offs_d = v.offs;
      w_st   = e_st;
      e_st   = d_st;
      w_name = e_name;
      e_name = d_name;
      s = '0;
      s.valid = vld && !(e_st.valid && e_st.taken);  // shadow of a taken branch
      if (s.valid) begin
         a       = model_regs[v.rs1];
         b       = v.use_imm ? v.imm : model_regs[v.rs2];
         is_link = (v.op == exu_op_pkg::op_bl) || (v.op == exu_op_pkg::op_jirl);
         s.taken  = directed && v.exp_taken;  // random rows are ALU ops only
         s.target = ((v.op == exu_op_pkg::op_jirl) ? a : pc) + v.offs;
         s.wen    = v.wen;
         s.rd     = v.rd;
         if (v.op == exu_op_pkg::op_bl) begin
            s.wen = 1'b1;
            s.rd  = 5'd1;
         end else if (v.op inside {[exu_op_pkg::op_beq : exu_op_pkg::op_b]}) begin
            s.wen = 1'b0;
         end
         if (!s.wen) s.rd = '0;
         s.data = is_link ? pc + 32'd4 : alu_ref(v.op, a, b);
         if (s.wen && s.rd != '0) model_regs[s.rd] = s.data;
         if (directed) s.data = v.exp_data;
      end
      d_st   = s;
      d_name = name;
      @(negedge clk);
      compare_outputs();
   endtask

   initial begin
      vec_t idle;
      vec_t rv;
      int   cnt;
      clk       = 1'b0;
      reset     = 1'b1;
      valid_d   = 1'b0;
      op_d      = exu_op_pkg::op_add;
      rs1_d     = '0;
      rs2_d     = '0;
      rd_d      = '0;
      rf_wen_d  = 1'b0;
      use_imm_d = 1'b0;
      imm_d     = '0;
      pc_d      = '0;
      br_offs_d = '0;
      lfsr      = 32'hdb36_4614;
      errors    = 0;
      checks    = 0;
      d_st      = '0;
      e_st      = '0;
      w_st      = '0;
      idle      = '0;
      for (int i = 0; i < exu_cfg_pkg::num_regs; i++) model_regs[i] = '0;

      cnt = 0;
      while (cnt < reset_cycles) begin
         @(posedge clk);
         cnt++;
      end
      #1 reset = 1'b0;
      @(negedge clk);
      check_value("reset wb_valid", 32'h0, 32'(wb_valid));
      check_value("reset br_taken_e", 32'h0, 32'(br_taken_e));

      for (int i = 0; i < num_vectors; i++) begin
         issue(1'b1, vectors[i], 32'h1000 + 32'(4 * i), 1'b1,
               $sformatf("directed row %0d", i));
      end

      for (int i = 0; i < num_random; i++) begin
         rv         = '0;
         rv.op      = exu_op_pkg::exu_op_e'(5'(take_bits(4) % 12));
         rv.rs1     = 5'(take_bits(5));
         rv.rs2     = 5'(take_bits(5));
         rv.rd      = 5'(take_bits(5));
         rv.wen     = 1'b1;
         rv.use_imm = take_bits(1) != 0;
         rv.imm     = take_bits(32);
         issue(1'b1, rv, 32'h2000 + 32'(4 * i), 1'b0, $sformatf("random %0d", i));
      end

      // let the last rows commit
      cnt = 0;
      while ((d_st.valid || e_st.valid || w_st.valid || wb_valid !== 1'b0) &&
             cnt < drain_timeout) begin
         issue(1'b0, idle, '0, 1'b0, "idle");
         cnt++;
      end
      if (cnt >= drain_timeout) begin
         errors++;
         $display("timeout: pipeline did not drain");
      end

      $display("checks run %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

// File: exu.f
+incdir+include
hw/exu_cfg_pkg.sv
hw/exu_op_pkg.sv
hw/exu_issue_if.sv
hw/exu_reg_file.sv
hw/exu_issue.sv
hw/exu_alu.sv
hw/exu_bru.sv
hw/exu_wb.sv
hw/exu.sv
verification/exu_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary -j 0
TOP       ?= exu_tb
FILELIST  ?= exu.f
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check $(LOG) for the pass message"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "Everything OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
